/* files.f */
source/display_pkg.sv
source/spi_slave_rx.sv
source/raster_timing.sv
source/panel_controller.sv
source/display_top.sv
dv/tb_clock_gen.sv
dv/display_assert.sv
dv/display_tb.sv

/* Makefile */
SRC := $(shell cat files.f)
SIM := obj_dir/Vdisplay_tb

.PHONY: all run clean

all: run

$(SIM): files.f $(SRC)
	verilator --binary --timing --assert --top-module display_tb \
		-f files.f -o Vdisplay_tb

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/display_tb.sv */
`timescale 1ns/1ns

module display_tb;

    // one raster frame is 48 by 22 cycles, and one SPI frame of up to
    // three bytes with its gaps stays below 120 cycles.
    localparam int FRAME_CYCLES = 48 * 22;
    localparam int SPI_FRAMES   = 30;
    localparam int TIMEOUT      = 8 * FRAME_CYCLES + SPI_FRAMES * 120;

    logic clk_system;
    logic rstn_system;
    logic spi_sclk;
    logic spi_ssn;
    logic spi_mosi;
    logic spi_miso;
    logic [7:0] seg;
    logic vga_hsync;
    logic vga_vsync;
    logic [3:0] vga_red;
    logic [3:0] vga_green;
    logic [3:0] vga_blue;

    // reference copies of what the host wrote, used by the assertions.
    display_pkg::byte_t exp_seg = 8'h00;
    display_pkg::byte_t ref_fg = 8'h00;
    display_pkg::byte_t ref_bg = 8'h00;
    display_pkg::byte_t ref_blue = 8'h00;
    display_pkg::byte_t last_data = 8'h00;
    display_pkg::byte_t rb_expect = 8'h00;
    display_pkg::byte_t rb_got = 8'h00;
    display_pkg::byte_t rb_shift = 8'h00;
    logic seg_pending = 1'b0;
    logic reg_pending = 1'b0;
    logic rb_check = 1'b0;
    int rb_bits = 0;
    int err_count = 0;
    int test_count = 0;
    int cycle_count = 0;
    logic [31:0] lfsr_state = 32'h3780e006;

    tb_clock_gen u_tb_clock_gen (
        .clk_system  (clk_system),
        .rstn_system (rstn_system)
    );

    display_top #(
        .H_ACTIVE (32), .H_FRONT (4), .H_SYNC (6), .H_BACK (6),
        .V_ACTIVE (16), .V_FRONT (2), .V_SYNC (2), .V_BACK (2)
    ) u_display_top (
        .clk_system  (clk_system),
        .rstn_system (rstn_system),
        .spi_sclk    (spi_sclk),
        .spi_ssn     (spi_ssn),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .seg         (seg),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_red     (vga_red),
        .vga_green   (vga_green),
        .vga_blue    (vga_blue)
    );

    bind display_top display_assert u_display_assert (.*);

    // ***********************************************************************
    // stimulus helpers
    // ***********************************************************************

    // taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic rand_byte(output display_pkg::byte_t value);
        value = 8'h00;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[6:0], lfsr_state[0]};
        end
    endtask

    // SCLK is low for three cycles and high for one. miso is sampled just
    // as SCLK rises, which is what a mode 0 host does.
    task automatic spi_bit(input logic value);
        @(negedge clk_system);
        spi_sclk = 1'b0;
        spi_mosi = value;
        repeat (3) @(negedge clk_system);
        if (rb_bits < 8) begin
            rb_shift = {rb_shift[6:0], spi_miso};
            rb_bits++;
        end
        spi_sclk = 1'b1;
    endtask

    task automatic spi_bits(input display_pkg::byte_t value, input int count);
        for (int i = 7; i > 7 - count; i--) begin
            spi_bit(value[i]);
        end
    endtask

    // the write lands four cycles after the last rising edge, and the
    // registered pixel one cycle later.
    task automatic commit_write(input display_pkg::reg_addr_t addr,
                                input display_pkg::byte_t data);
        seg_pending = 1'b1;
        reg_pending = 1'b1;
        case (addr)
            display_pkg::REG_SEG:  exp_seg = ~data;
            display_pkg::REG_FG:   ref_fg = data;
            display_pkg::REG_BG:   ref_bg = data;
            display_pkg::REG_BLUE: ref_blue = data;
        endcase
        last_data = data;
        repeat (4) @(posedge clk_system);
        @(negedge clk_system);
        seg_pending = 1'b0;
        @(negedge clk_system);
        reg_pending = 1'b0;
    endtask

    // data_bits below 8 cuts the frame short; extra adds a third byte.
    task automatic send_frame(input display_pkg::reg_addr_t addr,
                              input display_pkg::byte_t data,
                              input int data_bits,
                              input logic extra);
        display_pkg::byte_t junk;
        @(negedge clk_system);
        spi_ssn = 1'b0;
        rb_bits = 0;
        rb_expect = last_data;
        spi_bits({6'b000000, addr}, 8);
        if (data_bits == 8) begin
            spi_bits(data, 7);
            spi_bit(data[0]);
            commit_write(addr, data);
            if (extra) begin
                rand_byte(junk);
                spi_bits(junk, 8);
            end
        end else begin
            spi_bits(data, data_bits);
        end
        @(negedge clk_system);
        spi_sclk = 1'b0;
        repeat (2) @(negedge clk_system);
        spi_ssn = 1'b1;
        rb_got = rb_shift;
        rb_check = 1'b1;
        @(negedge clk_system);
        rb_check = 1'b0;
        repeat (6) @(negedge clk_system);
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, err_count - errs_before);
    endtask

    // ***********************************************************************
    // test sequence
    // ***********************************************************************

    initial begin
        int errs_before;
        display_pkg::byte_t data;
        spi_sclk = 1'b0;
        spi_ssn = 1'b1;
        spi_mosi = 1'b0;
        wait (rstn_system);

        errs_before = err_count;
        repeat (3) @(negedge vga_vsync);
        report_test("raster sync", errs_before);

        errs_before = err_count;
        rand_byte(data);
        send_frame(display_pkg::REG_SEG, data, 8, 1'b0);
        rand_byte(data);
        send_frame(display_pkg::REG_SEG, data, 8, 1'b0);
        report_test("segment write", errs_before);

        errs_before = err_count;
        rand_byte(data);
        send_frame(display_pkg::REG_FG, data, 8, 1'b0);
        rand_byte(data);
        send_frame(display_pkg::REG_BG, data, 8, 1'b0);
        rand_byte(data);
        send_frame(display_pkg::REG_BLUE, data, 8, 1'b0);
        repeat (2) @(negedge vga_vsync);
        report_test("colours and blanking", errs_before);

        errs_before = err_count;
        rand_byte(data);
        send_frame(display_pkg::REG_FG, data, 5, 1'b0);
        rand_byte(data);
        send_frame(display_pkg::REG_SEG, data, 8, 1'b1);
        rand_byte(data);
        send_frame(display_pkg::REG_BG, data, 8, 1'b1);
        @(negedge vga_vsync);
        report_test("framing", errs_before);

        errs_before = err_count;
        for (int i = 0; i < 4; i++) begin
            rand_byte(data);
            send_frame(display_pkg::reg_addr_t'(i), data, 8, 1'b0);
        end
        send_frame(display_pkg::REG_SEG, 8'h00, 3, 1'b0);
        report_test("readback", errs_before);

        $display("%0d tests run, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    always @(posedge clk_system) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT) begin
            $display("the run hung and was stopped after %0d cycles", TIMEOUT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

endmodule

/* dv/display_assert.sv */
`timescale 1ns/1ns

// checks on the display outputs, bound into display_top.
// the expected register contents come from the testbench top.
module display_assert #(
    parameter int H_ACTIVE = 32,
    parameter int H_TOTAL  = 48,
    parameter int H_SYNC   = 6,
    parameter int V_ACTIVE = 16,
    parameter int V_TOTAL  = 22,
    parameter int V_SYNC   = 2
) (
    input logic                clk_system,
    input logic                rstn_system,
    input logic [7:0]          seg,
    input logic                vga_hsync,
    input logic                vga_vsync,
    input logic [3:0]          vga_red,
    input logic [3:0]          vga_green,
    input logic [3:0]          vga_blue,
    input display_pkg::coord_t pix_x,
    input display_pkg::coord_t pix_y
);

    localparam int H_HIGH = H_TOTAL - H_SYNC;
    localparam int V_LOW  = V_SYNC * H_TOTAL;
    localparam int V_HIGH = (V_TOTAL - V_SYNC) * H_TOTAL;

    localparam display_pkg::coord_t X_ACTIVE_END = display_pkg::coord_t'(H_ACTIVE);
    localparam display_pkg::coord_t Y_ACTIVE_END = display_pkg::coord_t'(V_ACTIVE);

    logic                 h_prev;
    logic                 v_prev;
    logic                 h_armed;
    logic                 v_armed;
    int                   h_run;
    int                   v_run;
    logic                 active_q;
    display_pkg::coord_t  x_q;
    display_pkg::coord_t  y_q;
    display_pkg::rgb444_t rgb;
    display_pkg::rgb444_t fg_exp;
    display_pkg::rgb444_t bg_exp;
    logic                 tile_fg;

    // ***********************************************************************
    // run lengths of the sync levels and the position behind the pins
    // ***********************************************************************

    // a run counter holds the length of the finished run at each change.
    // the first run after reset is partial and arms the check.
    // the visible area is the top left H_ACTIVE by V_ACTIVE block of the raster.
    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            h_prev   <= 1'b1;
            v_prev   <= 1'b1;
            h_armed  <= 1'b0;
            v_armed  <= 1'b0;
            h_run    <= 0;
            v_run    <= 0;
            active_q <= 1'b0;
            x_q      <= '0;
            y_q      <= '0;
        end else begin
            h_prev   <= vga_hsync;
            v_prev   <= vga_vsync;
            h_run    <= (vga_hsync != h_prev) ? 1 : h_run + 1;
            v_run    <= (vga_vsync != v_prev) ? 1 : v_run + 1;
            h_armed  <= h_armed | (vga_hsync != h_prev);
            v_armed  <= v_armed | (vga_vsync != v_prev);
            active_q <= (pix_x < X_ACTIVE_END) && (pix_y < Y_ACTIVE_END);
            x_q      <= pix_x;
            y_q      <= pix_y;
        end
    end

    assign rgb     = {vga_red, vga_green, vga_blue};
    assign fg_exp  = {display_tb.ref_fg, display_tb.ref_blue[3:0]};
    assign bg_exp  = {display_tb.ref_bg, display_tb.ref_blue[7:4]};
    assign tile_fg = (x_q[display_pkg::TILE_SHIFT] != y_q[display_pkg::TILE_SHIFT]);

    // ***********************************************************************
    // assertions
    // ***********************************************************************

    hsync_low: assert property (@(posedge clk_system) disable iff (!rstn_system)
        (h_armed && vga_hsync && !h_prev) |-> (h_run == H_SYNC))
        else begin
            $error("ERR %0t: hsync low for %0d cycles", $time, h_run);
            display_tb.err_count = display_tb.err_count + 1;
        end

    hsync_high: assert property (@(posedge clk_system) disable iff (!rstn_system)
        (h_armed && !vga_hsync && h_prev) |-> (h_run == H_HIGH))
        else begin
            $error("ERR %0t: hsync high for %0d cycles", $time, h_run);
            display_tb.err_count = display_tb.err_count + 1;
        end

    vsync_low: assert property (@(posedge clk_system) disable iff (!rstn_system)
        (v_armed && vga_vsync && !v_prev) |-> (v_run == V_LOW))
        else begin
            $error("ERR %0t: vsync low for %0d cycles", $time, v_run);
            display_tb.err_count = display_tb.err_count + 1;
        end

    vsync_high: assert property (@(posedge clk_system) disable iff (!rstn_system)
        (v_armed && !vga_vsync && v_prev) |-> (v_run == V_HIGH))
        else begin
            $error("ERR %0t: vsync high for %0d cycles", $time, v_run);
            display_tb.err_count = display_tb.err_count + 1;
        end

    // active_q is cleared by reset, so this also covers the reset state.
    blanking: assert property (@(posedge clk_system) !active_q |-> (rgb == '0))
        else begin
            $error("ERR %0t: rgb %h outside the active area", $time, rgb);
            display_tb.err_count = display_tb.err_count + 1;
        end

    pixel_colour: assert property (@(posedge clk_system) disable iff (!rstn_system)
        (active_q && !display_tb.reg_pending) |-> (rgb == (tile_fg ? fg_exp : bg_exp)))
        else begin
            $error("ERR %0t: rgb %h at (%0d,%0d)", $time, rgb, x_q, y_q);
            display_tb.err_count = display_tb.err_count + 1;
        end

    seg_value: assert property (@(posedge clk_system) disable iff (!rstn_system)
        !display_tb.seg_pending |-> (seg == display_tb.exp_seg))
        else begin
            $error("ERR %0t: seg %h, expected %h", $time, seg, display_tb.exp_seg);
            display_tb.err_count = display_tb.err_count + 1;
        end

    regs_hold: assert property (@(posedge clk_system) disable iff (!rstn_system)
        !display_tb.reg_pending |->
            (u_panel_controller.fg_reg == display_tb.ref_fg) &&
            (u_panel_controller.bg_reg == display_tb.ref_bg) &&
            (u_panel_controller.blue_reg == display_tb.ref_blue))
        else begin
            $error("ERR %0t: colour registers differ from the frames sent", $time);
            display_tb.err_count = display_tb.err_count + 1;
        end

    readback_byte: assert property (@(posedge clk_system) disable iff (!rstn_system)
        display_tb.rb_check |-> (display_tb.rb_got == display_tb.rb_expect))
        else begin
            $error("ERR %0t: miso gave %h, expected %h", $time,
                   display_tb.rb_got, display_tb.rb_expect);
            display_tb.err_count = display_tb.err_count + 1;
        end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ns

// system clock and power-on reset for the testbench.
module tb_clock_gen #(
    parameter int HALF_PERIOD = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_system,
    output logic rstn_system
);

    initial begin
        clk_system = 1'b0;
        forever #HALF_PERIOD clk_system = ~clk_system;
    end

    // reset is released on a falling edge, like every other input.
    initial begin
        rstn_system = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_system);
        @(negedge clk_system);
        rstn_system = 1'b1;
    end

endmodule

/* source/display_top.sv */
`timescale 1ns/1ns

// display and control subsystem, all on clk_system.
module display_top #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic       clk_system,
    input  logic       rstn_system,
    input  logic       spi_sclk,
    input  logic       spi_ssn,
    input  logic       spi_mosi,
    output logic       spi_miso,
    output logic [7:0] seg,
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic [3:0] vga_red,
    output logic [3:0] vga_green,
    output logic [3:0] vga_blue
);

    display_pkg::byte_t  byte_rx;
    display_pkg::byte_t  readback;
    logic                byte_valid;
    logic                frame_start;
    display_pkg::coord_t pix_x;
    display_pkg::coord_t pix_y;
    logic                active;
    logic                hsync_raw;
    logic                vsync_raw;

    // ***********************************************************************
    // SPI link
    // ***********************************************************************

    spi_slave_rx u_spi_slave_rx (
        .clk_system  (clk_system),
        .rstn_system (rstn_system),
        .spi_sclk    (spi_sclk),
        .spi_ssn     (spi_ssn),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .readback    (readback),
        .byte_rx     (byte_rx),
        .byte_valid  (byte_valid),
        .frame_start (frame_start)
    );

    // ***********************************************************************
    // raster and panel
    // ***********************************************************************

    raster_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) u_raster_timing (
        .clk_system  (clk_system),
        .rstn_system (rstn_system),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .active      (active),
        .hsync_raw   (hsync_raw),
        .vsync_raw   (vsync_raw)
    );

    panel_controller u_panel_controller (
        .clk_system  (clk_system),
        .rstn_system (rstn_system),
        .byte_rx     (byte_rx),
        .byte_valid  (byte_valid),
        .frame_start (frame_start),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .active      (active),
        .hsync_raw   (hsync_raw),
        .vsync_raw   (vsync_raw),
        .readback    (readback),
        .seg         (seg),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_red     (vga_red),
        .vga_green   (vga_green),
        .vga_blue    (vga_blue)
    );

endmodule

/* source/panel_controller.sv */
`timescale 1ns/1ns

// turns SPI frames into control registers and paints the checkerboard.
module panel_controller (
    input  logic                clk_system,
    input  logic                rstn_system,
    input  display_pkg::byte_t  byte_rx,
    input  logic                byte_valid,
    input  logic                frame_start,
    input  display_pkg::coord_t pix_x,
    input  display_pkg::coord_t pix_y,
    input  logic                active,
    input  logic                hsync_raw,
    input  logic                vsync_raw,
    output display_pkg::byte_t  readback,
    output logic [7:0]          seg,
    output logic                vga_hsync,
    output logic                vga_vsync,
    output logic [3:0]          vga_red,
    output logic [3:0]          vga_green,
    output logic [3:0]          vga_blue
);

    // ***********************************************************************
    // frame decoder
    // ***********************************************************************

    display_pkg::frame_state_t state;
    display_pkg::reg_addr_t    addr_q;
    logic                      write_en;

    // out of reset we wait for a select, so stray bytes are not taken
    // as an address.
    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            state  <= display_pkg::FRAME_DONE;
            addr_q <= display_pkg::REG_SEG;
        end else if (frame_start) begin
            state <= display_pkg::FRAME_ADDR;
        end else if (byte_valid) begin
            case (state)
                display_pkg::FRAME_ADDR: begin
                    addr_q <= display_pkg::reg_addr_t'(byte_rx[1:0]);
                    state  <= display_pkg::FRAME_DATA;
                end
                display_pkg::FRAME_DATA: begin
                    state <= display_pkg::FRAME_DONE;
                end
                default: begin
                    state <= display_pkg::FRAME_DONE;
                end
            endcase
        end
    end

    assign write_en = byte_valid && !frame_start && (state == display_pkg::FRAME_DATA);

    // ***********************************************************************
    // control registers
    // ***********************************************************************

    display_pkg::byte_t fg_reg;
    display_pkg::byte_t bg_reg;
    display_pkg::byte_t blue_reg;

    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            seg      <= 8'h00;
            fg_reg   <= '0;
            bg_reg   <= '0;
            blue_reg <= '0;
            readback <= '0;
        end else if (write_en) begin
            // every complete frame is echoed back, whatever its address.
            readback <= byte_rx;
            case (addr_q)
                display_pkg::REG_SEG:  seg      <= ~byte_rx;
                display_pkg::REG_FG:   fg_reg   <= byte_rx;
                display_pkg::REG_BG:   bg_reg   <= byte_rx;
                display_pkg::REG_BLUE: blue_reg <= byte_rx;
            endcase
        end
    end

    // ***********************************************************************
    // pixel path
    // ***********************************************************************

    display_pkg::rgb444_t fg_color;
    display_pkg::rgb444_t bg_color;
    display_pkg::rgb444_t pixel;
    display_pkg::rgb444_t rgb_q;
    logic                 tile_fg;

    assign fg_color = {fg_reg, blue_reg[3:0]};
    assign bg_color = {bg_reg, blue_reg[7:4]};

    // neighbouring tiles alternate in both directions.
    assign tile_fg = pix_x[display_pkg::TILE_SHIFT] ^ pix_y[display_pkg::TILE_SHIFT];

    assign pixel = !active ? '0 : (tile_fg ? fg_color : bg_color);

    // colour and sync share one register stage so they reach the pins together.
    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            rgb_q     <= '0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
        end else begin
            rgb_q     <= pixel;
            vga_hsync <= hsync_raw;
            vga_vsync <= vsync_raw;
        end
    end

    assign vga_red   = rgb_q[11:8];
    assign vga_green = rgb_q[7:4];
    assign vga_blue  = rgb_q[3:0];

endmodule

/* source/raster_timing.sv */
`timescale 1ns/1ns

// free running raster counters, one pixel per clock.
// each line is active, front porch, sync, back porch, in that order,
// and the frame is built the same way from lines.
module raster_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                clk_system,
    input  logic                rstn_system,
    output display_pkg::coord_t pix_x,
    output display_pkg::coord_t pix_y,
    output logic                active,
    output logic                hsync_raw,
    output logic                vsync_raw
);

    // ***********************************************************************
    // interval boundaries
    // ***********************************************************************

    localparam display_pkg::coord_t H_ACTIVE_END = display_pkg::coord_t'(H_ACTIVE);
    localparam display_pkg::coord_t H_SYNC_START =
        display_pkg::coord_t'(H_ACTIVE + H_FRONT);
    localparam display_pkg::coord_t H_SYNC_END =
        display_pkg::coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam display_pkg::coord_t H_LAST =
        display_pkg::coord_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);

    localparam display_pkg::coord_t V_ACTIVE_END = display_pkg::coord_t'(V_ACTIVE);
    localparam display_pkg::coord_t V_SYNC_START =
        display_pkg::coord_t'(V_ACTIVE + V_FRONT);
    localparam display_pkg::coord_t V_SYNC_END =
        display_pkg::coord_t'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam display_pkg::coord_t V_LAST =
        display_pkg::coord_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

    display_pkg::coord_t h_count;
    display_pkg::coord_t v_count;

    // ***********************************************************************
    // counters
    // ***********************************************************************

    // the line counter only moves when a line wraps.
    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == H_LAST) begin
            h_count <= '0;
            if (v_count == V_LAST) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 11'd1;
            end
        end else begin
            h_count <= h_count + 11'd1;
        end
    end

    // ***********************************************************************
    // decoded outputs
    // ***********************************************************************

    // these stay combinational; the panel controller adds the single
    // pipeline stage in front of the pins.
    assign pix_x = h_count;
    assign pix_y = v_count;

    assign active = (h_count < H_ACTIVE_END) && (v_count < V_ACTIVE_END);

    // sync pulses are active low.
    assign hsync_raw = !((h_count >= H_SYNC_START) && (h_count < H_SYNC_END));
    assign vsync_raw = !((v_count >= V_SYNC_START) && (v_count < V_SYNC_END));

endmodule

/* source/spi_slave_rx.sv */
`timescale 1ns/1ns

// mode 0 SPI slave running entirely in the system clock domain.
// the pins are oversampled, so SCLK must be well below clk_system.
module spi_slave_rx (
    input  logic                clk_system,
    input  logic                rstn_system,
    input  logic                spi_sclk,
    input  logic                spi_ssn,
    input  logic                spi_mosi,
    output logic                spi_miso,
    input  display_pkg::byte_t  readback,
    output display_pkg::byte_t  byte_rx,
    output logic                byte_valid,
    output logic                frame_start
);

    // ***********************************************************************
    // pin synchronisers and edge detection
    // ***********************************************************************

    logic [1:0] sclk_sync;
    logic [1:0] ssn_sync;
    logic [1:0] mosi_sync;
    logic       sclk_prev;
    logic       ssn_prev;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       ssn_fall;

    // ssn idles high, so its flops come out of reset high and no false
    // frame start is seen when reset is released.
    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            sclk_sync <= 2'b00;
            ssn_sync  <= 2'b11;
            mosi_sync <= 2'b00;
            sclk_prev <= 1'b0;
            ssn_prev  <= 1'b1;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_sclk};
            ssn_sync  <= {ssn_sync[0], spi_ssn};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            sclk_prev <= sclk_sync[1];
            ssn_prev  <= ssn_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    assign sclk_fall = ~sclk_sync[1] & sclk_prev;
    assign ssn_fall  = ~ssn_sync[1] & ssn_prev;

    // ***********************************************************************
    // receive path
    // ***********************************************************************

    logic [2:0]         bit_cnt;
    display_pkg::byte_t shift_in;

    // the counter is held at zero while deselected, which throws away
    // any partial byte when ssn rises early.
    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            bit_cnt     <= 3'd0;
            byte_valid  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            frame_start <= ssn_fall;
            byte_valid  <= sclk_rise && !ssn_sync[1] && (bit_cnt == 3'd7);
            if (ssn_sync[1]) begin
                bit_cnt <= 3'd0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
            end
        end
    end

    // MSB arrives first.
    always_ff @(posedge clk_system) begin
        if (sclk_rise) begin
            shift_in <= {shift_in[6:0], mosi_sync[1]};
        end
        if (sclk_rise && !ssn_sync[1] && (bit_cnt == 3'd7)) begin
            byte_rx <= {shift_in[6:0], mosi_sync[1]};
        end
    end

    // ***********************************************************************
    // transmit path
    // ***********************************************************************

    display_pkg::byte_t shift_out;

    // the readback byte is loaded as the frame opens, so its MSB is on
    // the pin before the first rising SCLK edge. the host samples on
    // rising edges, we move on to the next bit on falling edges.
    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            shift_out <= '0;
        end else if (ssn_fall) begin
            shift_out <= readback;
        end else if (sclk_fall && !ssn_sync[1]) begin
            shift_out <= {shift_out[6:0], 1'b0};
        end
    end

    assign spi_miso = shift_out[7];

endmodule

/* source/display_pkg.sv */
// ***************************************************************************
// shared types and constants of the display subsystem
// ***************************************************************************

package display_pkg;

    // one byte as it moves over the SPI link.
    typedef logic [7:0] byte_t;

    // pixel or line position, wide enough for any common raster.
    typedef logic [10:0] coord_t;

    // colour packed as red, green and blue nibbles, red on top.
    typedef logic [11:0] rgb444_t;

    // the address byte of a frame only uses its two low bits.
    typedef logic [1:0] reg_addr_t;

    // ***********************************************************************
    // register map
    // ***********************************************************************

    // the data byte of a segment write is shown inverted on the display.
    localparam reg_addr_t REG_SEG = 2'd0;

    // foreground red in the high nibble and green in the low nibble.
    localparam reg_addr_t REG_FG = 2'd1;

    // background, same layout as the foreground register.
    localparam reg_addr_t REG_BG = 2'd2;

    // blue of both colours, foreground low nibble and background high nibble.
    localparam reg_addr_t REG_BLUE = 2'd3;

    // a frame is an address byte followed by a data byte.
    // anything after the data byte waits for the next select.
    typedef enum logic [1:0] {
        FRAME_ADDR,
        FRAME_DATA,
        FRAME_DONE
    } frame_state_t;

    // the checkerboard tiles are 2**TILE_SHIFT pixels on a side.
    localparam int TILE_SHIFT = 3;

endpackage
